//--- Bender.yml
package:
  name: mem_stage

sources:
  - source/mem_stage_pkg.sv
  - source/dirty_bit_tracker.sv
  - source/data_memory.sv
  - source/mem_wb_register.sv
  - source/mem_stage_top.sv
  - target: test
    files:
      - dv/mem_stage_sva.sv
      - dv/mem_stage_tb.sv

//--- dv/mem_stage_sva.sv
`default_nettype none

module mem_stage_sva
   import mem_stage_pkg::*;
(
   input wire logic    i_clock,
   input wire logic    i_soft_reset,
   input wire logic    i_enable_pipeline,
   input wire ex_mem_t i_ex_mem,
   input wire mem_wb_t o_mem_wb
);

   timeunit 1ns;
   timeprecision 100ps;

   // Number of failed properties so far.
   int unsigned failure_count = 0;

   // Write-back sees an idle bundle right after a reset edge.
   reset_clears_output: assert property (
      @(posedge i_clock) !i_soft_reset |=> (o_mem_wb == '0)
   ) else begin
      $error("o_mem_wb is not zero after a soft reset edge");
      failure_count++;
   end

   // A stalled edge leaves the output untouched.
   stall_holds_output: assert property (
      @(posedge i_clock) (i_soft_reset && !i_enable_pipeline) |=> $stable(o_mem_wb)
   ) else begin
      $error("o_mem_wb changed across a stalled edge");
      failure_count++;
   end

   // Only the three listed sizes ever reach the stage.
   access_size_legal: assert property (
      @(posedge i_clock) i_enable_pipeline |->
         (i_ex_mem.access_size inside {size_byte, size_half, size_word})
   ) else begin
      $error("i_ex_mem.access_size holds an unlisted value");
      failure_count++;
   end

endmodule

bind mem_stage_top mem_stage_sva mem_stage_sva_inst (
   .i_clock           (i_clock),
   .i_soft_reset      (i_soft_reset),
   .i_enable_pipeline (i_enable_pipeline),
   .i_ex_mem          (i_ex_mem),
   .o_mem_wb          (o_mem_wb)
);

`default_nettype wire

//--- dv/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb
   import mem_stage_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // Random stream seed and run length.
   localparam logic [31:0] seed = 32'he4114f21;
   localparam int num_bundles = 800;
   // First word of the 16-word window where random traffic collides.
   localparam logic [mem_word_addr_bits-1:0] window_base = 10'h1c0;
   // Cycles allowed for the last expectations to be checked.
   localparam int drain_limit = 20;

   logic    clock;
   logic    soft_reset;
   logic    enable_pipeline;
   ex_mem_t ex_mem;
   mem_wb_t mem_wb;

   // Reference memory with one written flag per word.
   logic [mem_word_bits-1:0] model_mem [mem_depth];
   logic                     model_valid [mem_depth];
   // One expected result per accepted bundle.
   mem_wb_t                  expect_queue [$];
   logic [31:0]              rng_state;

   mem_stage_top mem_stage_top_inst (
      .i_clock           (clock),
      .i_soft_reset      (soft_reset),
      .i_enable_pipeline (enable_pipeline),
      .i_ex_mem          (ex_mem),
      .o_mem_wb          (mem_wb)
   );

   // 10 ns clock.
   initial begin : clock_gen
      clock = 1'b0;
      forever begin
         #5 clock = ~clock;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers and reference model.
   //////////////////////////////////////////////////

   // Xorshift32 step.
   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic void clear_model();
      foreach (model_valid[i]) begin
         model_valid[i] = 1'b0;
      end
   endfunction

   // Random bundle inside the collision window.
   function automatic ex_mem_t random_bundle();
      ex_mem_t     b;
      logic [31:0] r;
      r = next_random();
      b = '0;
      case (r[2:0])
         3'd0, 3'd1, 3'd2: b.mem_read = 1'b1;
         3'd3, 3'd4, 3'd5: b.mem_write = 1'b1;
         3'd6: begin
            b.mem_read  = 1'b1;
            b.mem_write = 1'b1;
         end
         default: begin
         end
      endcase
      b.access_size   = access_size_e'(r[4:3] % 2'd3);
      b.load_unsigned = r[5];
      b.reg_write     = r[6];
      b.mem_to_reg    = r[7];
      b.halt          = r[8];
      b.dest_reg      = r[13:9];
      // Low address bits stay random and the misaligned part is ignored.
      b.addr          = {window_base + mem_word_addr_bits'(r[17:14]), r[19:18]};
      b.store_data    = next_random();
      b.alu_result    = next_random();
      return b;
   endfunction

   // Expected write-back bundle before the model takes the store.
   function automatic mem_wb_t predict_mem_wb(input ex_mem_t b);
      mem_wb_t                       p;
      logic [mem_word_addr_bits-1:0] word;
      logic [1:0]                    offset;
      logic [mem_word_bits-1:0]      cur;
      logic [mem_word_bits-1:0]      placed;
      logic [3:0]                    lanes;
      p            = '0;
      p.reg_write  = b.reg_write;
      p.mem_to_reg = b.mem_to_reg;
      p.dest_reg   = b.dest_reg;
      p.halt       = b.halt;
      p.alu_result = b.alu_result;
      word         = b.addr[mem_byte_addr_bits-1:2];
      offset       = b.addr[1:0];
      // Words not written since reset read as zero.
      cur = model_valid[word] ? model_mem[word] : '0;
      if (b.mem_read) begin
         p.load_was_dirty = model_valid[word];
         case (b.access_size)
            size_byte: begin
               p.load_data = (cur >> (8 * offset)) & 32'h0000_00ff;
               if (!b.load_unsigned && p.load_data[7]) begin
                  p.load_data = p.load_data | 32'hffff_ff00;
               end
            end
            size_half: begin
               p.load_data = offset[1] ? (cur >> 16) : (cur & 32'h0000_ffff);
               if (!b.load_unsigned && p.load_data[15]) begin
                  p.load_data = p.load_data | 32'hffff_0000;
               end
            end
            default: p.load_data = cur;
         endcase
      end
      // The load above saw the old word and the store lands after it.
      if (b.mem_write) begin
         case (b.access_size)
            size_byte: begin
               lanes  = 4'b0001 << offset;
               placed = {24'h0, b.store_data[7:0]} << (8 * offset);
            end
            size_half: begin
               lanes  = offset[1] ? 4'b1100 : 4'b0011;
               placed = offset[1] ? {b.store_data[15:0], 16'h0} : {16'h0, b.store_data[15:0]};
            end
            default: begin
               lanes  = 4'b1111;
               placed = b.store_data;
            end
         endcase
         for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
               cur[8*lane +: 8] = placed[8*lane +: 8];
            end
         end
         model_mem[word]   = cur;
         model_valid[word] = 1'b1;
      end
      return p;
   endfunction

   // Drives one cycle 1 ns after the edge.
   // Accepted bundles queue a prediction.
   task automatic apply_bundle(input ex_mem_t bundle, input logic enable, input logic reset_n);
      @(posedge clock);
      #1;
      ex_mem          = bundle;
      enable_pipeline = enable;
      soft_reset      = reset_n;
      if (!reset_n) begin
         clear_model();
      end else if (enable) begin
         expect_queue.push_back(predict_mem_wb(bundle));
      end
   endtask

   //////////////////////////////////////////////////
   // Comparison.
   //////////////////////////////////////////////////

   task automatic check_field(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("Error at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic compare_bundle(input mem_wb_t expected, input mem_wb_t actual);
      check_field("o_mem_wb.reg_write", 32'(expected.reg_write), 32'(actual.reg_write));
      check_field("o_mem_wb.mem_to_reg", 32'(expected.mem_to_reg), 32'(actual.mem_to_reg));
      check_field("o_mem_wb.dest_reg", 32'(expected.dest_reg), 32'(actual.dest_reg));
      check_field("o_mem_wb.halt", 32'(expected.halt), 32'(actual.halt));
      check_field("o_mem_wb.alu_result", expected.alu_result, actual.alu_result);
      check_field("o_mem_wb.load_data", expected.load_data, actual.load_data);
      check_field("o_mem_wb.load_was_dirty", 32'(expected.load_was_dirty),
                  32'(actual.load_was_dirty));
   endtask

   // Inputs are sampled at the edge and the output at the falling edge.
   initial begin : compare_process
      mem_wb_t expected;
      mem_wb_t held;
      logic    reset_seen;
      logic    enable_seen;
      held = '0;
      forever begin
         @(posedge clock);
         reset_seen  = soft_reset;
         enable_seen = enable_pipeline;
         @(negedge clock);
         if (!reset_seen) begin
            expected = '0;
         end else if (enable_seen && expect_queue.size() == 0) begin
            $display("A bundle was accepted but no expected result was queued");
            $display("Simulation failed");
            $fatal(1);
         end else if (enable_seen) begin
            expected = expect_queue.pop_front();
         end else begin
            // A stalled edge must hold the previous bundle.
            expected = held;
         end
         compare_bundle(expected, mem_wb);
         held = expected;
         // Bound assertions fired at the last edge.
         if (mem_stage_top_inst.mem_stage_sva_inst.failure_count != 0) begin
            $display("A bound assertion on the DUT failed");
            $display("Simulation failed");
            $fatal(1);
         end
      end
   end

   //////////////////////////////////////////////////
   // Stimulus.
   //////////////////////////////////////////////////

   initial begin : stimulus
      ex_mem_t     bundle;
      logic [31:0] r;
      int          wait_cycles;
      rng_state       = seed;
      soft_reset      = 1'b0;
      enable_pipeline = 1'b0;
      ex_mem          = '0;
      clear_model();
      // Reset covers the first three rising edges.
      apply_bundle('0, 1'b0, 1'b0);
      apply_bundle('0, 1'b0, 1'b0);
      // Loads anywhere in memory right after reset.
      for (int i = 0; i < 32; i++) begin
         bundle           = random_bundle();
         r                = next_random();
         bundle.mem_read  = 1'b1;
         bundle.mem_write = 1'b0;
         bundle.addr      = r[mem_byte_addr_bits-1:0];
         apply_bundle(bundle, 1'b1, 1'b1);
      end
      // Window traffic with stall stretches and rare soft resets.
      for (int i = 0; i < num_bundles; i++) begin
         r = next_random();
         if (r[6:0] == 7'd0) begin
            // Enable is random here and must be ignored.
            for (int k = 0; k <= int'(r[8:7]); k++) begin
               apply_bundle(random_bundle(), r[9+k], 1'b0);
            end
         end
         if (r[12:10] < 3'd2) begin
            // Stores driven while stalled must not land.
            for (int k = 0; k <= int'(r[15:13]); k++) begin
               apply_bundle(random_bundle(), 1'b0, 1'b1);
            end
         end
         apply_bundle(random_bundle(), 1'b1, 1'b1);
      end
      apply_bundle('0, 1'b0, 1'b1);
      wait_cycles = 0;
      while (expect_queue.size() != 0 && wait_cycles < drain_limit) begin
         @(posedge clock);
         wait_cycles++;
      end
      if (expect_queue.size() != 0) begin
         $display("Timeout: queued results were not checked within %0d cycles", drain_limit);
         $display("Simulation failed");
         $fatal(1);
      end else if (mem_stage_top_inst.mem_stage_sva_inst.failure_count != 0) begin
         $display("A bound assertion on the DUT failed");
         $display("Simulation failed");
         $fatal(1);
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- source/data_memory.sv
`default_nettype none

module data_memory
   import mem_stage_pkg::*;
(
   input  wire logic                          i_clock,
   input  wire logic                          i_soft_reset,
   input  wire logic                          i_enable,
   input  wire logic [mem_byte_addr_bits-1:0] i_addr,
   input  wire access_size_e                  i_access_size,
   input  wire logic                          i_load_unsigned,
   input  wire logic                          i_mem_read,
   input  wire logic                          i_mem_write,
   input  wire logic [mem_word_bits-1:0]      i_store_data,
   output logic      [mem_word_bits-1:0]      o_load_data,
   output logic                               o_load_was_dirty
);

   // Address split into word index and byte lane.
   logic [mem_word_addr_bits-1:0] word_addr;
   logic [1:0]                    byte_offset;
   // Flag of the addressed word before this edge.
   logic                          dirty_now;
   logic                          store_en;
   logic [3:0]                    lane_mask;
   logic [3:0]                    lane_we;
   logic [mem_word_bits-1:0]      store_src;
   logic [mem_word_bits-1:0]      store_word;
   logic [mem_word_bits-1:0]      ram [mem_depth];
   // Registered read side.
   logic [mem_word_bits-1:0]      raw_q;
   logic [1:0]                    offset_q;
   access_size_e                  size_q;
   logic                          unsigned_q;
   logic                          read_q;
   logic                          dirty_q;
   // Output side helpers.
   logic [mem_word_bits-1:0]      clean_word;
   logic [7:0]                    byte_sel;
   logic [15:0]                   half_sel;
   logic [mem_word_bits-1:0]      extended;

   assign word_addr   = i_addr[mem_byte_addr_bits-1:2];
   assign byte_offset = i_addr[1:0];

   // No store lands in a soft reset cycle or while stalled.
   assign store_en = i_soft_reset & i_enable & i_mem_write;

   dirty_bit_tracker dirty_bit_tracker_inst (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_word_addr  (word_addr),
      .i_set        (store_en),
      .o_dirty      (dirty_now)
   );

   //////////////////////////////////////////////////
   // Store lane steering.
   //////////////////////////////////////////////////

   // Lanes are picked by size and offset.
   // Data is replicated so any lane can take it.
   // Halfwords use bit 1 only and ignore bit 0.
   always_comb begin
      case (i_access_size)
         size_byte: begin
            lane_mask = 4'b0001 << byte_offset;
            store_src = {4{i_store_data[7:0]}};
         end
         size_half: begin
            lane_mask = byte_offset[1] ? 4'b1100 : 4'b0011;
            store_src = {2{i_store_data[15:0]}};
         end
         default: begin
            lane_mask = 4'b1111;
            store_src = i_store_data;
         end
      endcase
   end

   // Unselected lanes carry zero.
   // A clean word is written whole, so its untouched bytes become zero in RAM.
   always_comb begin
      for (int lane = 0; lane < 4; lane++) begin
         store_word[8*lane +: 8] = lane_mask[lane] ? store_src[8*lane +: 8] : 8'h00;
      end
      lane_we = dirty_now ? lane_mask : 4'b1111;
   end

   // Read-first RAM with byte write enables.
   // The registered word is the content from before this edge.
   always_ff @(posedge i_clock) begin
      if (i_enable) begin
         raw_q      <= ram[word_addr];
         offset_q   <= byte_offset;
         size_q     <= i_access_size;
         unsigned_q <= i_load_unsigned;
      end
      for (int lane = 0; lane < 4; lane++) begin
         if (store_en && lane_we[lane]) begin
            ram[word_addr][8*lane +: 8] <= store_word[8*lane +: 8];
         end
      end
   end

   // Read qualifiers decide whether anything comes out at all.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         read_q  <= 1'b0;
         dirty_q <= 1'b0;
      end else if (i_enable) begin
         read_q  <= i_mem_read;
         dirty_q <= dirty_now;
      end
   end

   //////////////////////////////////////////////////
   // Load extraction.
   //////////////////////////////////////////////////

   // Words never written since reset read as zero.
   assign clean_word = dirty_q ? raw_q : '0;
   assign byte_sel   = clean_word[8*offset_q +: 8];
   assign half_sel   = offset_q[1] ? clean_word[31:16] : clean_word[15:0];

   // Sign or zero extension of the selected lane.
   always_comb begin
      case (size_q)
         size_byte: extended = unsigned_q ? {{(mem_word_bits-8){1'b0}}, byte_sel}
                                          : {{(mem_word_bits-8){byte_sel[7]}}, byte_sel};
         size_half: extended = unsigned_q ? {{(mem_word_bits-16){1'b0}}, half_sel}
                                          : {{(mem_word_bits-16){half_sel[15]}}, half_sel};
         default:   extended = clean_word;
      endcase
   end

   // Non-loads give zero data and a low flag.
   assign o_load_data      = read_q ? extended : '0;
   assign o_load_was_dirty = read_q & dirty_q;

endmodule

`default_nettype wire

//--- source/dirty_bit_tracker.sv
`default_nettype none

module dirty_bit_tracker
   import mem_stage_pkg::*;
(
   input  wire logic                          i_clock,
   input  wire logic                          i_soft_reset,
   input  wire logic [mem_word_addr_bits-1:0] i_word_addr,
   input  wire logic                          i_set,
   output logic                               o_dirty
);

   //////////////////////////////////////////////////
   // Per-word written flags.
   //////////////////////////////////////////////////

   // One flag per memory word.
   // A set flag means the word was stored to since the last soft reset.
   logic [mem_depth-1:0] dirty_q;

   // Soft reset wipes every flag in a single cycle.
   // This is what lets the RAM itself keep stale data after reset.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         dirty_q <= '0;
      end else begin
         // Flags are only ever set here.
         // They only go back to zero through the soft reset.
         if (i_set) begin
            dirty_q[i_word_addr] <= 1'b1;
         end
      end
   end

   // Combinational lookup of the addressed word.
   // A store in this same cycle is not seen yet, so the old flag comes out.
   assign o_dirty = dirty_q[i_word_addr];

endmodule

`default_nettype wire

//--- source/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

   //////////////////////////////////////////////////
   // Memory geometry.
   //////////////////////////////////////////////////

   // Data word width.
   localparam int mem_word_bits = 32;
   // Number of words in the data memory.
   localparam int mem_depth = 1024;
   // Word address width as log2 of the depth.
   localparam int mem_word_addr_bits = 10;
   // Byte address width with two extra lane bits.
   localparam int mem_byte_addr_bits = 12;
   // Register file index width.
   localparam int reg_index_bits = 5;

   // Access size, shared by stores and loads.
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } access_size_e;

   //////////////////////////////////////////////////
   // Stage bundles.
   //////////////////////////////////////////////////

   // Bundle coming from the execute stage.
   typedef struct packed {
      logic                          reg_write;
      logic                          mem_read;
      logic                          mem_write;
      logic                          mem_to_reg;
      access_size_e                  access_size;
      logic                          load_unsigned;
      logic [mem_byte_addr_bits-1:0] addr;
      logic [mem_word_bits-1:0]      store_data;
      logic [mem_word_bits-1:0]      alu_result;
      logic [reg_index_bits-1:0]     dest_reg;
      logic                          halt;
   } ex_mem_t;

   // Bundle going to write-back.
   typedef struct packed {
      logic                      reg_write;
      logic                      mem_to_reg;
      logic [reg_index_bits-1:0] dest_reg;
      logic                      halt;
      logic [mem_word_bits-1:0]  alu_result;
      // Already sign or zero extended.
      logic [mem_word_bits-1:0]  load_data;
      logic                      load_was_dirty;
   } mem_wb_t;

endpackage

`default_nettype wire

//--- source/mem_stage_top.sv
`default_nettype none

module mem_stage_top
   import mem_stage_pkg::*;
(
   input  wire logic    i_clock,
   input  wire logic    i_soft_reset,
   input  wire logic    i_enable_pipeline,
   input  wire ex_mem_t i_ex_mem,
   output mem_wb_t      o_mem_wb
);

   //////////////////////////////////////////////////
   // Data memory stage.
   //////////////////////////////////////////////////

   // Load result, already registered inside the memory.
   logic [mem_word_bits-1:0] load_data;
   // Set when the loaded word was written since reset.
   logic                     load_was_dirty;

   // Memory side of the bundle.
   // The global stall doubles as the memory enable.
   data_memory data_memory_inst (
      .i_clock          (i_clock),
      .i_soft_reset     (i_soft_reset),
      .i_enable         (i_enable_pipeline),
      .i_addr           (i_ex_mem.addr),
      .i_access_size    (i_ex_mem.access_size),
      .i_load_unsigned  (i_ex_mem.load_unsigned),
      .i_mem_read       (i_ex_mem.mem_read),
      .i_mem_write      (i_ex_mem.mem_write),
      .i_store_data     (i_ex_mem.store_data),
      .o_load_data      (load_data),
      .o_load_was_dirty (load_was_dirty)
   );

   // MEM/WB register.
   // Control goes in whole and load results join at the output.
   mem_wb_register mem_wb_register_inst (
      .i_clock          (i_clock),
      .i_soft_reset     (i_soft_reset),
      .i_enable         (i_enable_pipeline),
      .i_ex_mem         (i_ex_mem),
      .i_load_data      (load_data),
      .i_load_was_dirty (load_was_dirty),
      .o_mem_wb         (o_mem_wb)
   );

endmodule

`default_nettype wire

//--- source/mem_wb_register.sv
`default_nettype none

module mem_wb_register
   import mem_stage_pkg::*;
(
   input  wire logic                     i_clock,
   input  wire logic                     i_soft_reset,
   input  wire logic                     i_enable,
   input  wire ex_mem_t                  i_ex_mem,
   input  wire logic [mem_word_bits-1:0] i_load_data,
   input  wire logic                     i_load_was_dirty,
   output mem_wb_t                       o_mem_wb
);

   //////////////////////////////////////////////////
   // Write-back control capture.
   //////////////////////////////////////////////////

   logic                      reg_write_q;
   logic                      mem_to_reg_q;
   logic [reg_index_bits-1:0] dest_reg_q;
   logic                      halt_q;
   logic [mem_word_bits-1:0]  alu_result_q;

   // Everything clears on reset so write-back sees an idle bundle.
   // A stall simply holds the previous bundle.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         reg_write_q  <= 1'b0;
         mem_to_reg_q <= 1'b0;
         dest_reg_q   <= '0;
         halt_q       <= 1'b0;
         alu_result_q <= '0;
      end else if (i_enable) begin
         reg_write_q  <= i_ex_mem.reg_write;
         mem_to_reg_q <= i_ex_mem.mem_to_reg;
         dest_reg_q   <= i_ex_mem.dest_reg;
         halt_q       <= i_ex_mem.halt;
         alu_result_q <= i_ex_mem.alu_result;
      end
   end

   // Load fields come from the RAM output register.
   // They line up with the captured control without another flop.
   always_comb begin
      o_mem_wb.reg_write      = reg_write_q;
      o_mem_wb.mem_to_reg     = mem_to_reg_q;
      o_mem_wb.dest_reg       = dest_reg_q;
      o_mem_wb.halt           = halt_q;
      o_mem_wb.alu_result     = alu_result_q;
      o_mem_wb.load_data      = i_load_data;
      o_mem_wb.load_was_dirty = i_load_was_dirty;
   end

endmodule

`default_nettype wire

//--- sources.f
source/mem_stage_pkg.sv
source/dirty_bit_tracker.sv
source/data_memory.sv
source/mem_wb_register.sv
source/mem_stage_top.sv
dv/mem_stage_sva.sv
dv/mem_stage_tb.sv
